/* gpu_defines.svh */
`ifndef GPU_DEFINES_SVH
`define GPU_DEFINES_SVH

`default_nettype none

// coordinates, sizes and scales
`define GPU_COORD_W 16

// byte address on the read bus
`define GPU_ADDR_W 32

// AXI-Lite read data
`define GPU_WORD_W 32

// framebuffer and colour table entries
`define GPU_COLOUR_W 16

`default_nettype wire

`endif

/* gpu_pkg.sv */
`include "gpu_defines.svh"
`default_nettype none

package gpu_pkg;

    typedef enum logic [4:0] {
        BPP_1  = 5'd1,
        BPP_2  = 5'd2,
        BPP_4  = 5'd4,
        BPP_8  = 5'd8,
        BPP_16 = 5'd16
    } bpp_e;

    typedef struct packed {
        logic [`GPU_ADDR_W-1:0]         image;          // sheet base, byte address
        logic [`GPU_COORD_W-1:0]        image_x;
        logic [`GPU_COORD_W-1:0]        image_y;
        logic [`GPU_COORD_W-1:0]        image_width;    // in pixels
        logic signed [`GPU_COORD_W-1:0] scale_x;        // >0 repeat, <0 skip
        logic signed [`GPU_COORD_W-1:0] scale_y;
        logic                           flip_x;
        logic                           flip_y;
        bpp_e                           bpp;
        logic                           ct_enable;
        logic [`GPU_COLOUR_W-1:0]       ct_offset;
        logic [`GPU_COORD_W-1:0]        excerpt_width;
        logic [`GPU_COORD_W-1:0]        excerpt_height;
        logic [`GPU_COORD_W-1:0]        screen_x;
        logic [`GPU_COORD_W-1:0]        screen_y;
    } blit_cmd_t;

    typedef struct packed {
        logic [2*`GPU_COORD_W-1:0] sheet_x;
        logic [2*`GPU_COORD_W-1:0] sheet_y;
        logic [`GPU_COORD_W-1:0]   fb_x;
        logic [`GPU_COORD_W-1:0]   fb_y;
    } pixel_pos_t;

    typedef struct packed {
        logic [`GPU_ADDR_W-1:0]  addr;      // word aligned
        logic [4:0]              bit_off;   // counted from the word msb
        logic [`GPU_COORD_W-1:0] fb_x;
        logic [`GPU_COORD_W-1:0] fb_y;
    } fetch_req_t;

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    typedef union packed {
        rgb565_t                  rgb;      // direct colour
        logic [`GPU_COLOUR_W-1:0] index;    // colour table entry
    } pixel_data_u;

    typedef struct packed {
        logic [`GPU_COORD_W-1:0]  x;
        logic [`GPU_COORD_W-1:0]  y;
        logic [`GPU_COLOUR_W-1:0] colour;
    } fb_pixel_t;

endpackage

`default_nettype wire

/* gpu_rect_gen.sv */
`timescale 1ns/1ns
`include "gpu_defines.svh"
`default_nettype none

module gpu_rect_gen (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  gpu_pkg::blit_cmd_t  cmd,
    output gpu_pkg::pixel_pos_t out_pos,
    output logic                out_valid,
    input  logic                out_ready,
    output logic                done
);

    localparam int SS_W = 2 * `GPU_COORD_W;

    logic                    active;
    logic [`GPU_COORD_W-1:0] x;         // excerpt column
    logic [`GPU_COORD_W-1:0] y;         // excerpt row
    logic [`GPU_COORD_W-1:0] sub_x;     // repeat count when upscaling
    logic [`GPU_COORD_W-1:0] sub_y;
    logic [SS_W-1:0]         ss_x;
    logic [SS_W-1:0]         ss_y;
    logic [`GPU_COORD_W-1:0] mag_x;
    logic [`GPU_COORD_W-1:0] mag_y;
    logic                    last_x;
    logic                    last_y;
    logic                    handshake;

    assign mag_x = cmd.scale_x[`GPU_COORD_W-1] ? -cmd.scale_x : cmd.scale_x;
    assign mag_y = cmd.scale_y[`GPU_COORD_W-1] ? -cmd.scale_y : cmd.scale_y;

    assign last_x    = x == cmd.excerpt_width - 1'b1;
    assign last_y    = y == cmd.excerpt_height - 1'b1;
    assign out_valid = active;
    assign handshake = out_valid && out_ready;
    assign done      = handshake && last_x && last_y;

    always_comb begin
        out_pos.sheet_x = ss_x;
        out_pos.sheet_y = ss_y;
        // mirrored within the excerpt
        out_pos.fb_x = cmd.flip_x ? cmd.screen_x + cmd.excerpt_width - 1'b1 - x
                                  : cmd.screen_x + x;
        out_pos.fb_y = cmd.flip_y ? cmd.screen_y + cmd.excerpt_height - 1'b1 - y
                                  : cmd.screen_y + y;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
        end else if (start) begin
            active <= 1'b1;
        end else if (done) begin
            active <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            x     <= '0;
            y     <= '0;
            sub_x <= '0;
            sub_y <= '0;
            ss_x  <= SS_W'(cmd.image_x);
            ss_y  <= SS_W'(cmd.image_y);
        end else if (handshake) begin
            if (last_x) begin
                x     <= '0;
                sub_x <= '0;
                ss_x  <= SS_W'(cmd.image_x);   // back to the row start
                y     <= y + 1'b1;
                if (cmd.scale_y[`GPU_COORD_W-1]) begin
                    ss_y <= ss_y + SS_W'(mag_y);
                end else if (sub_y == mag_y - 1'b1) begin
                    sub_y <= '0;
                    ss_y  <= ss_y + 1'b1;
                end else begin
                    sub_y <= sub_y + 1'b1;
                end
            end else begin
                x <= x + 1'b1;
                if (cmd.scale_x[`GPU_COORD_W-1]) begin
                    ss_x <= ss_x + SS_W'(mag_x);   // downscale skips pixels
                end else if (sub_x == mag_x - 1'b1) begin
                    sub_x <= '0;
                    ss_x  <= ss_x + 1'b1;
                end else begin
                    sub_x <= sub_x + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* gpu_address.sv */
`timescale 1ns/1ns
`include "gpu_defines.svh"
`default_nettype none

module gpu_address (
    input  logic                clk,
    input  logic                rst,
    input  gpu_pkg::blit_cmd_t  cmd,
    input  gpu_pkg::pixel_pos_t in_pos,
    input  logic                in_valid,
    output logic                in_ready,
    output gpu_pkg::fetch_req_t out_req,
    output logic                out_valid,
    input  logic                out_ready
);

    logic [`GPU_ADDR_W-1:0] lin_index;
    logic [`GPU_ADDR_W-1:0] bit_addr;
    logic [`GPU_ADDR_W-1:0] byte_addr;
    gpu_pkg::fetch_req_t    calc_req;
    gpu_pkg::fetch_req_t    skid_req;
    logic                   skid_valid;
    logic                   out_free;

    assign lin_index = in_pos.sheet_y * cmd.image_width + in_pos.sheet_x;
    assign bit_addr  = lin_index * cmd.bpp;
    assign byte_addr = cmd.image + (bit_addr >> 3);

    always_comb begin
        calc_req.addr    = {byte_addr[`GPU_ADDR_W-1:2], 2'b00};
        calc_req.bit_off = {byte_addr[1:0], bit_addr[2:0]};    // bit position in the word
        calc_req.fb_x    = in_pos.fb_x;
        calc_req.fb_y    = in_pos.fb_y;
    end

    assign in_ready = !skid_valid;
    assign out_free = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            out_valid  <= skid_valid || in_valid;
            skid_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            skid_valid <= 1'b1;    // downstream stalled, park it
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            out_req <= skid_valid ? skid_req : calc_req;
        end else if (in_valid && in_ready) begin
            skid_req <= calc_req;
        end
    end

endmodule

`default_nettype wire

/* gpu_fetch.sv */
`timescale 1ns/1ns
`include "gpu_defines.svh"
`default_nettype none

module gpu_fetch (
    input  logic                     clk,
    input  logic                     rst,
    input  gpu_pkg::blit_cmd_t       cmd,
    input  gpu_pkg::fetch_req_t      in_req,
    input  logic                     in_valid,
    output logic                     in_ready,
    output logic [`GPU_ADDR_W-1:0]   araddr,
    output logic                     arvalid,
    input  logic                     arready,
    input  logic [`GPU_WORD_W-1:0]   rdata,
    input  logic                     rvalid,
    output logic                     rready,
    output gpu_pkg::pixel_data_u     out_data,
    output logic [`GPU_COORD_W-1:0]  out_x,
    output logic [`GPU_COORD_W-1:0]  out_y,
    output logic                     out_valid,
    input  logic                     out_ready
);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_AR   = 2'd1;
    localparam logic [1:0] S_R    = 2'd2;
    localparam logic [1:0] S_OUT  = 2'd3;

    logic [1:0]             state;
    gpu_pkg::fetch_req_t    req_q;
    logic [`GPU_ADDR_W-1:0] cache_addr;
    logic [`GPU_WORD_W-1:0] cache_data;
    logic                   cache_valid;
    logic                   hit;

    // msb first, zero extended
    function automatic logic [`GPU_COLOUR_W-1:0] extract(
        input logic [`GPU_WORD_W-1:0] word,
        input logic [4:0]             off,
        input gpu_pkg::bpp_e          bpp
    );
        logic [5:0]             shift;
        logic [`GPU_WORD_W-1:0] shifted;
        logic [`GPU_COLOUR_W:0] mask;
        shift   = 6'd32 - {1'b0, off} - {1'b0, bpp};
        shifted = word >> shift;
        mask    = ({{`GPU_COLOUR_W{1'b0}}, 1'b1} << bpp) - 1'b1;
        return shifted[`GPU_COLOUR_W-1:0] & mask[`GPU_COLOUR_W-1:0];
    endfunction

    assign hit       = cache_valid && cache_addr == in_req.addr;
    assign in_ready  = state == S_IDLE;
    assign arvalid   = state == S_AR;
    assign rready    = state == S_R;
    assign out_valid = state == S_OUT;
    assign araddr    = req_q.addr;
    assign out_x     = req_q.fb_x;
    assign out_y     = req_q.fb_y;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= S_IDLE;
            cache_valid <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (in_valid) begin
                        state <= hit ? S_OUT : S_AR;   // bus only on a miss
                    end
                end
                S_AR: begin
                    if (arready) begin
                        state <= S_R;
                    end
                end
                S_R: begin
                    if (rvalid) begin
                        state       <= S_OUT;
                        cache_valid <= 1'b1;
                    end
                end
                default: begin
                    if (out_ready) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            req_q <= in_req;
            if (hit) begin
                out_data <= extract(cache_data, in_req.bit_off, cmd.bpp);
            end
        end
        if (rvalid && rready) begin
            cache_addr <= req_q.addr;
            cache_data <= rdata;
            out_data   <= extract(rdata, req_q.bit_off, cmd.bpp);
        end
    end

endmodule

`default_nettype wire

/* gpu_colour_write.sv */
`timescale 1ns/1ns
`include "gpu_defines.svh"
`default_nettype none

module gpu_colour_write (
    input  logic                     clk,
    input  logic                     rst,
    input  gpu_pkg::blit_cmd_t       cmd,
    input  gpu_pkg::pixel_data_u     in_data,
    input  logic [`GPU_COORD_W-1:0]  in_x,
    input  logic [`GPU_COORD_W-1:0]  in_y,
    input  logic                     in_valid,
    output logic [`GPU_COLOUR_W-1:0] ct_address,
    input  logic [`GPU_COLOUR_W-1:0] ct_colour,
    output logic [`GPU_COORD_W-1:0]  fb_x,
    output logic [`GPU_COORD_W-1:0]  fb_y,
    output logic [`GPU_COLOUR_W-1:0] fb_colour,
    output logic                     fb_write
);

    gpu_pkg::fb_pixel_t stage_q;    // waits for the table read
    logic               stage_valid;
    gpu_pkg::fb_pixel_t fb_q;

    // table memory answers on the next cycle
    assign ct_address = cmd.ct_offset + in_data.index;

    always_ff @(posedge clk) begin
        stage_q.x      <= in_x;
        stage_q.y      <= in_y;
        stage_q.colour <= {in_data.rgb.red, in_data.rgb.green, in_data.rgb.blue};

        fb_q.x      <= stage_q.x;
        fb_q.y      <= stage_q.y;
        fb_q.colour <= cmd.ct_enable ? ct_colour : stage_q.colour;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_valid <= 1'b0;
            fb_write    <= 1'b0;
        end else begin
            stage_valid <= in_valid;
            fb_write    <= stage_valid;
        end
    end

    assign fb_x      = fb_q.x;
    assign fb_y      = fb_q.y;
    assign fb_colour = fb_q.colour;

endmodule

`default_nettype wire

/* gpu_top.sv */
`timescale 1ns/1ns
`include "gpu_defines.svh"
`default_nettype none

module gpu_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`GPU_ADDR_W-1:0]   image,
    input  logic [`GPU_COORD_W-1:0]  image_x,
    input  logic [`GPU_COORD_W-1:0]  image_y,
    input  logic [`GPU_COORD_W-1:0]  image_width,
    input  logic [`GPU_COORD_W-1:0]  image_scale_x,   // signed
    input  logic [`GPU_COORD_W-1:0]  image_scale_y,   // signed
    input  logic                     image_flip_x,
    input  logic                     image_flip_y,
    input  gpu_pkg::bpp_e            bpp,
    input  logic                     ct_enable,
    input  logic [`GPU_COLOUR_W-1:0] ct_offset,
    input  logic [`GPU_COORD_W-1:0]  excerpt_width,
    input  logic [`GPU_COORD_W-1:0]  excerpt_height,
    input  logic [`GPU_COORD_W-1:0]  screen_x,
    input  logic [`GPU_COORD_W-1:0]  screen_y,
    input  logic                     command_draw,
    output logic                     is_busy,
    output logic [`GPU_ADDR_W-1:0]   araddr,
    output logic                     arvalid,
    input  logic                     arready,
    input  logic [`GPU_WORD_W-1:0]   rdata,
    input  logic                     rvalid,
    output logic                     rready,
    output logic [`GPU_COLOUR_W-1:0] ct_address,
    input  logic [`GPU_COLOUR_W-1:0] ct_colour,
    output logic [`GPU_COORD_W-1:0]  fb_x,
    output logic [`GPU_COORD_W-1:0]  fb_y,
    output logic [`GPU_COLOUR_W-1:0] fb_colour,
    output logic                     fb_write
);

    gpu_pkg::blit_cmd_t      cmd;
    logic                    accept;
    logic                    start;
    gpu_pkg::pixel_pos_t     pos;
    logic                    pos_valid;
    logic                    pos_ready;
    gpu_pkg::fetch_req_t     req;
    logic                    req_valid;
    logic                    req_ready;
    gpu_pkg::pixel_data_u    pix;
    logic [`GPU_COORD_W-1:0] pix_x;
    logic [`GPU_COORD_W-1:0] pix_y;
    logic                    pix_valid;
    logic                    gen_done;
    logic                    gen_finished;
    logic [2:0]              in_flight;   // at most 5 pixels past the generator
    logic                    last_write;

    assign accept     = command_draw && !is_busy;
    assign last_write = fb_write && gen_finished && in_flight == 3'd1;

    always_ff @(posedge clk) begin
        if (rst) begin
            is_busy      <= 1'b0;
            start        <= 1'b0;
            gen_finished <= 1'b0;
            in_flight    <= '0;
        end else begin
            start     <= accept;
            in_flight <= in_flight + 3'(pos_valid && pos_ready) - 3'(fb_write);
            if (accept) begin
                is_busy      <= 1'b1;
                gen_finished <= 1'b0;
            end else if (last_write) begin
                is_busy <= 1'b0;
            end else if (gen_done) begin
                gen_finished <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd.image          <= image;
            cmd.image_x        <= image_x;
            cmd.image_y        <= image_y;
            cmd.image_width    <= image_width;
            cmd.scale_x        <= image_scale_x;
            cmd.scale_y        <= image_scale_y;
            cmd.flip_x         <= image_flip_x;
            cmd.flip_y         <= image_flip_y;
            cmd.bpp            <= bpp;
            cmd.ct_enable      <= ct_enable;
            cmd.ct_offset      <= ct_offset;
            cmd.excerpt_width  <= excerpt_width;
            cmd.excerpt_height <= excerpt_height;
            cmd.screen_x       <= screen_x;
            cmd.screen_y       <= screen_y;
        end
    end

    gpu_rect_gen gpu_rect_gen_inst (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .cmd       (cmd),
        .out_pos   (pos),
        .out_valid (pos_valid),
        .out_ready (pos_ready),
        .done      (gen_done)
    );

    gpu_address gpu_address_inst (
        .clk       (clk),
        .rst       (rst),
        .cmd       (cmd),
        .in_pos    (pos),
        .in_valid  (pos_valid),
        .in_ready  (pos_ready),
        .out_req   (req),
        .out_valid (req_valid),
        .out_ready (req_ready)
    );

    gpu_fetch gpu_fetch_inst (
        .clk       (clk),
        .rst       (rst || start),   // cache flushed on every new draw
        .cmd       (cmd),
        .in_req    (req),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rvalid    (rvalid),
        .rready    (rready),
        .out_data  (pix),
        .out_x     (pix_x),
        .out_y     (pix_y),
        .out_valid (pix_valid),
        .out_ready (1'b1)            // colour stage never stalls
    );

    gpu_colour_write gpu_colour_write_inst (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .in_data    (pix),
        .in_x       (pix_x),
        .in_y       (pix_y),
        .in_valid   (pix_valid),
        .ct_address (ct_address),
        .ct_colour  (ct_colour),
        .fb_x       (fb_x),
        .fb_y       (fb_y),
        .fb_colour  (fb_colour),
        .fb_write   (fb_write)
    );

endmodule

`default_nettype wire

/* gpu_assertions.sv */
`timescale 1ns/1ns
`include "gpu_defines.svh"
`default_nettype none

module gpu_assertions (
    input logic                   clk,
    input logic                   rst,
    input logic                   pos_valid,
    input logic                   pos_ready,
    input gpu_pkg::pixel_pos_t    pos,
    input logic                   req_valid,
    input logic                   req_ready,
    input gpu_pkg::fetch_req_t    req,
    input logic                   arvalid,
    input logic                   arready,
    input logic [`GPU_ADDR_W-1:0] araddr,
    input logic                   pix_valid,
    input logic                   fb_write,
    input logic                   is_busy,
    input gpu_pkg::blit_cmd_t     cmd
);

    int error_count = 0;    // polled by the testbench

    pos_hold: assert property (@(posedge clk) disable iff (rst)
        pos_valid && !pos_ready |=> pos_valid && $stable(pos))
        else begin
            $error("generator output dropped or changed while stalled");
            error_count++;
        end

    req_hold: assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(req))
        else begin
            $error("address stage output dropped or changed while stalled");
            error_count++;
        end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            $error("arvalid or araddr changed before arready");
            error_count++;
        end

    // colour stage is always ready, so pix_valid is its accept
    write_after_accept: assert property (@(posedge clk) disable iff (rst)
        pix_valid |-> ##2 fb_write)
        else begin
            $error("no fb_write two cycles after the colour stage accepted");
            error_count++;
        end

    write_has_accept: assert property (@(posedge clk) disable iff (rst)
        fb_write |-> $past(pix_valid, 2))
        else begin
            $error("fb_write without an accept two cycles earlier");
            error_count++;
        end

    write_while_busy: assert property (@(posedge clk) disable iff (rst)
        fb_write |-> is_busy)
        else begin
            $error("fb_write while not busy");
            error_count++;
        end

    scale_nonzero: assert property (@(posedge clk) disable iff (rst)
        is_busy |-> cmd.scale_x != '0 && cmd.scale_y != '0)
        else begin
            $error("draw started with a zero scale");
            error_count++;
        end

endmodule

bind gpu_top gpu_assertions gpu_assertions_inst (
    .clk       (clk),
    .rst       (rst),
    .pos_valid (pos_valid),
    .pos_ready (pos_ready),
    .pos       (pos),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .arvalid   (arvalid),
    .arready   (arready),
    .araddr    (araddr),
    .pix_valid (pix_valid),
    .fb_write  (fb_write),
    .is_busy   (is_busy),
    .cmd       (cmd)
);

`default_nettype wire

/* tb_gpu.sv */
`timescale 1ns/1ns
`include "gpu_defines.svh"
`default_nettype none

module tb_gpu;

    localparam logic [31:0] SEED         = 32'd42;
    localparam int          DRAW_TIMEOUT = 4000;   // cycles per draw

    logic                     clk;
    logic                     rst;
    logic [`GPU_ADDR_W-1:0]   image;
    logic [`GPU_COORD_W-1:0]  image_x;
    logic [`GPU_COORD_W-1:0]  image_y;
    logic [`GPU_COORD_W-1:0]  image_width;
    logic [`GPU_COORD_W-1:0]  image_scale_x;
    logic [`GPU_COORD_W-1:0]  image_scale_y;
    logic                     image_flip_x;
    logic                     image_flip_y;
    gpu_pkg::bpp_e            bpp;
    logic                     ct_enable;
    logic [`GPU_COLOUR_W-1:0] ct_offset;
    logic [`GPU_COORD_W-1:0]  excerpt_width;
    logic [`GPU_COORD_W-1:0]  excerpt_height;
    logic [`GPU_COORD_W-1:0]  screen_x;
    logic [`GPU_COORD_W-1:0]  screen_y;
    logic                     command_draw;
    logic                     is_busy;
    logic [`GPU_ADDR_W-1:0]   araddr;
    logic                     arvalid;
    logic                     arready = 1'b0;
    logic [`GPU_WORD_W-1:0]   rdata = '0;
    logic                     rvalid = 1'b0;
    logic                     rready;
    logic [`GPU_COLOUR_W-1:0] ct_address;
    logic [`GPU_COLOUR_W-1:0] ct_colour = '0;
    logic [`GPU_COORD_W-1:0]  fb_x;
    logic [`GPU_COORD_W-1:0]  fb_y;
    logic [`GPU_COLOUR_W-1:0] fb_colour;
    logic                     fb_write;

    // axi slave and colour table model state
    logic [31:0]              rng_state = SEED;
    int                       ar_wait = 0;
    int                       r_wait = 0;
    logic                     read_pending = 1'b0;
    logic [`GPU_ADDR_W-1:0]   read_addr = '0;
    logic [`GPU_COLOUR_W-1:0] ct_addr_q = '0;
    int                       ar_transfers = 0;

    gpu_pkg::fb_pixel_t       expected[$];   // every draw appends here
    gpu_pkg::fb_pixel_t       exp_pix;
    int                       writes_seen = 0;
    gpu_pkg::blit_cmd_t       blit;
    int                       ar_used;

    gpu_top gpu_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] v);
        logic [31:0] x;
        x = v;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int next_delay();
        rng_state = xorshift32(rng_state);
        return int'(rng_state % 4);
    endfunction

    function automatic logic [15:0] table_colour(input logic [15:0] address);
        logic [31:0] v;
        v = xorshift32({16'd0, address});
        return v[15:0];
    endfunction

    task automatic stop_failed();
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("%0t ns: %s", $time, what);
        stop_failed();
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, want);
        stop_failed();
    endtask

    // slave answers with random arready and rvalid delays
    always @(negedge clk) begin
        if (arready) begin
            arready = 1'b0;    // handshake on the last rising edge
            ar_transfers++;
            read_pending = 1'b1;
            r_wait = next_delay();
        end else if (arvalid) begin
            if (ar_wait == 0) begin
                arready = 1'b1;
                read_addr = araddr;
                ar_wait = next_delay();
            end else begin
                ar_wait--;
            end
        end
        // rready only while a read is outstanding
        assert (rready == read_pending)
            else report_mismatch("rready", rready, read_pending);
        if (rvalid) begin
            rvalid = 1'b0;
        end else if (read_pending) begin
            if (r_wait == 0) begin
                rvalid = 1'b1;
                rdata = xorshift32(read_addr);
                read_pending = 1'b0;
            end else begin
                r_wait--;
            end
        end
        ct_colour = table_colour(ct_addr_q);    // one cycle behind ct_address
        ct_addr_q = ct_address;
    end

    always @(negedge clk) begin
        if (gpu_top_inst.gpu_assertions_inst.error_count != 0) begin
            report_failure("a bound protocol assertion failed");
        end
        if (fb_write) begin
            assert (writes_seen < expected.size())
                else report_failure("fb_write with no pixel left to expect");
            exp_pix = expected[writes_seen];
            assert (fb_x == exp_pix.x) else report_mismatch("fb_x", fb_x, exp_pix.x);
            assert (fb_y == exp_pix.y) else report_mismatch("fb_y", fb_y, exp_pix.y);
            assert (fb_colour == exp_pix.colour)
                else report_mismatch("fb_colour", fb_colour, exp_pix.colour);
            writes_seen++;
        end
    end

    // reference walk of the excerpt in raster order
    task automatic build_expected(input gpu_pkg::blit_cmd_t c);
        int          sx;
        int          sy;
        int          bits;
        int          r;
        int          col;
        int          row_src;
        int          col_src;
        logic [31:0] bit_addr;
        logic [31:0] word_addr;
        logic [31:0] word;
        logic [31:0] pix;
        gpu_pkg::fb_pixel_t p;
        sx = $signed(c.scale_x);
        sy = $signed(c.scale_y);
        bits = int'(c.bpp);
        for (r = 0; r < int'(c.excerpt_height); r++) begin
            row_src = (sy < 0) ? int'(c.image_y) + r * -sy : int'(c.image_y) + r / sy;
            for (col = 0; col < int'(c.excerpt_width); col++) begin
                col_src = (sx < 0) ? int'(c.image_x) + col * -sx : int'(c.image_x) + col / sx;
                bit_addr = (row_src * int'(c.image_width) + col_src) * bits;
                word_addr = (c.image + bit_addr / 8) & ~32'd3;
                word = xorshift32(word_addr);
                pix = (word >> (32 - bit_addr % 32 - bits)) & ((32'd1 << bits) - 1);
                p.x = c.flip_x ? c.screen_x + c.excerpt_width - 1 - col : c.screen_x + col;
                p.y = c.flip_y ? c.screen_y + c.excerpt_height - 1 - r : c.screen_y + r;
                p.colour = c.ct_enable ? table_colour(c.ct_offset + pix[15:0]) : pix[15:0];
                expected.push_back(p);
            end
        end
    endtask

    task automatic run_draw(input gpu_pkg::blit_cmd_t c, input logic poke_busy,
                            output int ars);
        int   ar_before;
        int   writes_before;
        int   cycles;
        logic last_write;
        ar_before = ar_transfers;
        writes_before = writes_seen;
        build_expected(c);
        image = c.image;
        image_x = c.image_x;
        image_y = c.image_y;
        image_width = c.image_width;
        image_scale_x = c.scale_x;
        image_scale_y = c.scale_y;
        image_flip_x = c.flip_x;
        image_flip_y = c.flip_y;
        bpp = c.bpp;
        ct_enable = c.ct_enable;
        ct_offset = c.ct_offset;
        excerpt_width = c.excerpt_width;
        excerpt_height = c.excerpt_height;
        screen_x = c.screen_x;
        screen_y = c.screen_y;
        command_draw = 1'b1;
        @(negedge clk);
        command_draw = 1'b0;
        assert (is_busy) else report_failure("is_busy did not rise after command_draw");
        if (poke_busy) begin
            repeat (3) @(negedge clk);
            screen_x = c.screen_x + 16'd7;    // must be ignored
            command_draw = 1'b1;
            @(negedge clk);
            command_draw = 1'b0;
        end
        cycles = 0;
        last_write = 1'b0;
        while (is_busy) begin
            last_write = fb_write;
            @(negedge clk);
            cycles++;
            if (cycles > DRAW_TIMEOUT) begin
                report_failure("draw did not finish before the timeout");
            end
        end
        assert (last_write)
            else report_failure("is_busy did not fall right after the last write");
        assert (writes_seen - writes_before == int'(c.excerpt_width) * int'(c.excerpt_height))
            else report_mismatch("pixel count", writes_seen - writes_before,
                                 int'(c.excerpt_width) * int'(c.excerpt_height));
        ars = ar_transfers - ar_before;
        @(negedge clk);
    endtask

    initial begin
        rst = 1'b1;
        command_draw = 1'b0;
        image = '0;
        image_x = '0;
        image_y = '0;
        image_width = '0;
        image_scale_x = 16'd1;
        image_scale_y = 16'd1;
        image_flip_x = 1'b0;
        image_flip_y = 1'b0;
        bpp = gpu_pkg::BPP_8;
        ct_enable = 1'b0;
        ct_offset = '0;
        excerpt_width = '0;
        excerpt_height = '0;
        screen_x = '0;
        screen_y = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // plain 16 bpp copy
        blit = '{image: 32'h0000_1000, image_x: 16'd3, image_y: 16'd2, image_width: 16'd40,
                 scale_x: 16'sd1, scale_y: 16'sd1, flip_x: 1'b0, flip_y: 1'b0,
                 bpp: gpu_pkg::BPP_16, ct_enable: 1'b0, ct_offset: 16'd0,
                 excerpt_width: 16'd6, excerpt_height: 16'd4,
                 screen_x: 16'd100, screen_y: 16'd50};
        run_draw(blit, 1'b0, ar_used);

        // colour table, packed pixels share words
        blit.bpp = gpu_pkg::BPP_1;
        blit.ct_enable = 1'b1;
        blit.ct_offset = 16'h0200;
        blit.excerpt_width = 16'd12;
        blit.excerpt_height = 16'd3;
        run_draw(blit, 1'b0, ar_used);
        assert (ar_used < 36) else report_failure("1 bpp draw never hit the word cache");
        blit.bpp = gpu_pkg::BPP_4;
        run_draw(blit, 1'b0, ar_used);
        assert (ar_used < 36) else report_failure("4 bpp draw never hit the word cache");

        // upscale, then downscale in x
        blit.bpp = gpu_pkg::BPP_8;
        blit.ct_enable = 1'b0;
        blit.scale_x = 16'sd3;
        blit.scale_y = 16'sd2;
        blit.excerpt_width = 16'd7;
        blit.excerpt_height = 16'd4;
        run_draw(blit, 1'b0, ar_used);
        blit.scale_x = -16'sd2;
        blit.scale_y = 16'sd1;
        blit.excerpt_width = 16'd6;
        run_draw(blit, 1'b0, ar_used);

        // mirrored in both axes
        blit.scale_x = 16'sd1;
        blit.flip_x = 1'b1;
        blit.flip_y = 1'b1;
        blit.bpp = gpu_pkg::BPP_2;
        blit.ct_enable = 1'b1;
        run_draw(blit, 1'b0, ar_used);

        // long 8 bpp draw with a second command while busy
        blit.flip_x = 1'b0;
        blit.flip_y = 1'b0;
        blit.bpp = gpu_pkg::BPP_8;
        blit.ct_enable = 1'b0;
        blit.excerpt_width = 16'd8;
        blit.excerpt_height = 16'd5;
        run_draw(blit, 1'b1, ar_used);

        if (gpu_top_inst.gpu_assertions_inst.error_count != 0) begin
            stop_failed();
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
gpu_pkg.sv
gpu_rect_gen.sv
gpu_address.sv
gpu_fetch.sv
gpu_colour_write.sv
gpu_top.sv
gpu_assertions.sv
tb_gpu.sv
